// File: hw/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// data and instruction word width
`define RV_XLEN 32

// architectural integer registers, x0 included
`define RV_NUM_REGS 32
`define RV_REG_ADDR_W 5

`endif

// File: hw/rv_pkg.sv
`default_nettype none

`include "rv_config.svh"

package rv_pkg;

    // one data or instruction word
    typedef logic [`RV_XLEN-1:0] word_t;

    // register index
    typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;

    // major opcodes handled by the core
    // anything else retires without a write
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    // alu function codes
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SLL  = 4'd1,
        ALU_XOR  = 4'd4,
        ALU_SRL  = 4'd5,
        ALU_OR   = 4'd6,
        ALU_AND  = 4'd7,
        ALU_NONE = 4'd8,
        ALU_SUB  = 4'd10,
        ALU_SRA  = 4'd11,
        ALU_SLT  = 4'd12,
        ALU_SLTU = 4'd14
    } alu_op_e;

endpackage

`default_nettype wire

// File: hw/issue_if.sv
`timescale 1ns/100ps
`default_nettype none

// decoded operation, decode to execute
interface issue_if;

    logic              valid;
    rv_pkg::alu_op_e   alu_op;
    rv_pkg::word_t     op_a;
    // rs2 value or sign-extended immediate
    rv_pkg::word_t     op_b;
    rv_pkg::reg_addr_t rd;

    modport src (
        output valid, alu_op, op_a, op_b, rd
    );

    modport dst (
        input valid, alu_op, op_a, op_b, rd
    );

endinterface

`default_nettype wire

// File: hw/result_if.sv
`timescale 1ns/100ps
`default_nettype none

// computed result from execute
interface result_if;

    logic              valid;
    rv_pkg::reg_addr_t rd;
    rv_pkg::word_t     data;
    // supported op with a nonzero rd
    logic              write_en;

    modport src  (output valid, rd, data, write_en);

    modport sink (input valid, rd, data, write_en);

    // decode looks here for results not yet written back
    modport fwd  (input valid, rd, data, write_en);

endinterface

`default_nettype wire

// File: hw/instr_fetch.sv
`timescale 1ns/100ps
`default_nettype none

module instr_fetch (
    input  wire                clk,
    input  wire                reset,
    input  wire rv_pkg::word_t instr,
    input  wire                instr_req,
    output logic               instr_ack,
    output logic               fetch_valid,
    output rv_pkg::word_t      fetch_instr
);

    logic accept;
    logic release_ack;

    // new request seen while idle
    assign accept = instr_req && !instr_ack;

    // producer has dropped req after seeing ack
    assign release_ack = !instr_req && instr_ack;

    // receiver side of the four-phase handshake
    always_ff @(posedge clk) begin
        if (reset) begin
            instr_ack <= 1'b0;
        end else if (accept) begin
            instr_ack <= 1'b1;
        end else if (release_ack) begin
            instr_ack <= 1'b0;
        end
    end

    // one-cycle offer to decode, the cycle after the accept edge
    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= accept;
        end
    end

    // word is stable while req is high and ack still low
    always_ff @(posedge clk) begin
        if (accept) begin
            fetch_instr <= instr;
        end
    end

endmodule

`default_nettype wire

// File: hw/instr_decode.sv
`timescale 1ns/100ps
`default_nettype none

module instr_decode (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    fetch_valid,
    input  wire rv_pkg::word_t     fetch_instr,
    output rv_pkg::reg_addr_t      rs1_addr,
    output rv_pkg::reg_addr_t      rs2_addr,
    input  wire rv_pkg::word_t     rs1_data,
    input  wire rv_pkg::word_t     rs2_data,
    issue_if.src                   issue,
    result_if.fwd                  fwd
);

    rv_pkg::opcode_e   opcode;
    rv_pkg::reg_addr_t rd;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    logic              supported;
    logic              is_reg_reg;
    rv_pkg::alu_op_e   alu_op;
    rv_pkg::word_t     imm_i;
    rv_pkg::word_t     rs1_val;
    rv_pkg::word_t     rs2_val;
    logic              fwd_hit1;
    logic              fwd_hit2;

    // instruction fields
    assign opcode   = rv_pkg::opcode_e'(fetch_instr[6:0]);
    assign rd       = fetch_instr[11:7];
    assign funct3   = fetch_instr[14:12];
    assign rs1_addr = fetch_instr[19:15];
    assign rs2_addr = fetch_instr[24:20];
    assign funct7   = fetch_instr[31:25];

    assign is_reg_reg = (opcode == rv_pkg::OPC_OP);
    assign supported  = is_reg_reg || (opcode == rv_pkg::OPC_OP_IMM);

    // sign-extended I immediate, shamt sits in the low five bits
    assign imm_i = {{20{fetch_instr[31]}}, fetch_instr[31:20]};

    // funct3 picks the function, funct7 bit 5 picks sub and sra
    always_comb begin
        case (funct3)
            3'b000: begin
                alu_op = (is_reg_reg && funct7[5]) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            end
            3'b001: alu_op = rv_pkg::ALU_SLL;
            3'b010: alu_op = rv_pkg::ALU_SLT;
            3'b011: alu_op = rv_pkg::ALU_SLTU;
            3'b100: alu_op = rv_pkg::ALU_XOR;
            3'b101: begin
                alu_op = funct7[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            end
            3'b110: alu_op = rv_pkg::ALU_OR;
            default: alu_op = rv_pkg::ALU_AND;
        endcase
        if (!supported) begin
            alu_op = rv_pkg::ALU_NONE;
        end
    end

    // previous result still in flight, not yet in the register file
    assign fwd_hit1 = fwd.valid && fwd.write_en && (fwd.rd == rs1_addr);
    assign fwd_hit2 = fwd.valid && fwd.write_en && (fwd.rd == rs2_addr);

    assign rs1_val = fwd_hit1 ? fwd.data : rs1_data;
    assign rs2_val = fwd_hit2 ? fwd.data : rs2_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            issue.valid <= 1'b0;
        end else begin
            issue.valid <= fetch_valid;
        end
    end

    // issue payload
    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            issue.alu_op <= alu_op;
            issue.op_a   <= rs1_val;
            issue.op_b   <= is_reg_reg ? rs2_val : imm_i;
            // unsupported ops retire with no destination
            issue.rd     <= supported ? rd : '0;
        end
    end

endmodule

`default_nettype wire

// File: hw/alu_execute.sv
`timescale 1ns/100ps
`default_nettype none

module alu_execute (
    input  wire   clk,
    input  wire   reset,
    issue_if.dst  issue,
    result_if.src result
);

    logic [4:0]    shamt;
    logic          lt_signed;
    logic          lt_unsigned;
    logic          writes_rd;
    rv_pkg::word_t alu_out;

    // shift amount from the low five bits of op_b
    assign shamt = issue.op_b[4:0];

    assign lt_signed   = $signed(issue.op_a) < $signed(issue.op_b);
    assign lt_unsigned = issue.op_a < issue.op_b;

    always_comb begin
        case (issue.alu_op)
            rv_pkg::ALU_ADD:  alu_out = issue.op_a + issue.op_b;
            rv_pkg::ALU_SUB:  alu_out = issue.op_a - issue.op_b;
            rv_pkg::ALU_SLL:  alu_out = issue.op_a << shamt;
            rv_pkg::ALU_SRL:  alu_out = issue.op_a >> shamt;
            // true arithmetic shift, sign bit fills from the top
            rv_pkg::ALU_SRA:  alu_out = $signed(issue.op_a) >>> shamt;
            rv_pkg::ALU_XOR:  alu_out = issue.op_a ^ issue.op_b;
            rv_pkg::ALU_OR:   alu_out = issue.op_a | issue.op_b;
            rv_pkg::ALU_AND:  alu_out = issue.op_a & issue.op_b;
            rv_pkg::ALU_SLT:  alu_out = rv_pkg::word_t'(lt_signed);
            rv_pkg::ALU_SLTU: alu_out = rv_pkg::word_t'(lt_unsigned);
            default:          alu_out = '0;
        endcase
    end

    // x0 and unsupported ops never write back
    assign writes_rd = (issue.rd != '0) && (issue.alu_op != rv_pkg::ALU_NONE);

    always_ff @(posedge clk) begin
        if (reset) begin
            result.valid    <= 1'b0;
            result.write_en <= 1'b0;
        end else begin
            result.valid    <= issue.valid;
            result.write_en <= issue.valid && writes_rd;
        end
    end

    // result payload
    always_ff @(posedge clk) begin
        if (issue.valid) begin
            result.rd   <= issue.rd;
            result.data <= alu_out;
        end
    end

endmodule

`default_nettype wire

// File: hw/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_config.svh"

module reg_file (
    input  wire                    clk,
    input  wire                    reset,
    input  wire rv_pkg::reg_addr_t rs1_addr,
    input  wire rv_pkg::reg_addr_t rs2_addr,
    output rv_pkg::word_t          rs1_data,
    output rv_pkg::word_t          rs2_data,
    result_if.sink                 wr
);

    rv_pkg::word_t regs [`RV_NUM_REGS];

    // combinational reads, x0 is hardwired to zero
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.valid && wr.write_en) begin
            // write_en is never set for rd zero
            regs[wr.rd] <= wr.data;
        end
    end

endmodule

`default_nettype wire

// File: hw/rv_core_top.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core_top (
    input  wire                clk,
    input  wire                reset,
    input  wire rv_pkg::word_t instr,
    input  wire                instr_req,
    output logic               instr_ack,
    output logic               wb_valid,
    output rv_pkg::reg_addr_t  wb_rd,
    output rv_pkg::word_t      wb_data
);

    logic              fetch_valid;
    rv_pkg::word_t     fetch_instr;
    rv_pkg::reg_addr_t rs1_addr;
    rv_pkg::reg_addr_t rs2_addr;
    rv_pkg::word_t     rs1_data;
    rv_pkg::word_t     rs2_data;

    issue_if  issue_bus ();
    result_if result_bus ();

    instr_fetch u_fetch (
        .clk         (clk),
        .reset       (reset),
        .instr       (instr),
        .instr_req   (instr_req),
        .instr_ack   (instr_ack),
        .fetch_valid (fetch_valid),
        .fetch_instr (fetch_instr)
    );

    instr_decode u_decode (
        .clk         (clk),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .fetch_instr (fetch_instr),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .issue       (issue_bus.src),
        .fwd         (result_bus.fwd)
    );

    alu_execute u_execute (
        .clk    (clk),
        .reset  (reset),
        .issue  (issue_bus.dst),
        .result (result_bus.src)
    );

    reg_file u_regs (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr       (result_bus.sink)
    );

    // writeback report, one pulse per register write
    assign wb_valid = result_bus.valid && result_bus.write_en;
    assign wb_rd    = result_bus.rd;
    assign wb_data  = result_bus.data;

endmodule

`default_nettype wire

// File: sim/rv_core_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core_assertions (
    input wire                    clk,
    input wire                    reset,
    input wire                    instr_req,
    input wire                    instr_ack,
    input wire                    wb_valid,
    input wire rv_pkg::reg_addr_t wb_rd
);

    int failures = 0;

    // ack only answers a raised request
    ack_rise_on_req: assert property (@(posedge clk) disable iff (reset)
        $rose(instr_ack) |-> $past(instr_req))
    else begin
        $error("instr_ack rose while instr_req was low");
        failures++;
    end

    // ack is released only after the producer dropped req
    ack_fall_on_idle: assert property (@(posedge clk) disable iff (reset)
        $fell(instr_ack) |-> !$past(instr_req))
    else begin
        $error("instr_ack fell while instr_req was high");
        failures++;
    end

    // accept edges are two cycles apart at best
    wb_single_pulse: assert property (@(posedge clk) disable iff (reset)
        wb_valid |=> !wb_valid)
    else begin
        $error("wb_valid held for two consecutive cycles");
        failures++;
    end

    wb_rd_nonzero: assert property (@(posedge clk) disable iff (reset)
        wb_valid |-> (wb_rd != '0))
    else begin
        $error("writeback reported for x0");
        failures++;
    end

endmodule

`default_nettype wire

// File: sim/rv_core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core_tb;

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 4;
    localparam int DRIVE_DELAY = 2;
    localparam logic [31:0] SEED = 32'd44;
    localparam int DIRECTED_INSTRS = 45;
    localparam int RANDOM_INSTRS = 200;
    // eight cycles covers a handshake plus the longest random gap
    localparam int WATCHDOG_CYCLES = (DIRECTED_INSTRS + RANDOM_INSTRS) * 8 + 200;

    localparam logic [6:0] OPC_REG = 7'b0110011;
    localparam logic [6:0] OPC_IMM = 7'b0010011;
    localparam logic [6:0] ALT_F7 = 7'b0100000;

    logic        clk;
    logic        reset;
    logic [31:0] instr;
    logic        instr_req;
    logic        instr_ack;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    logic [31:0] shadow [32];
    logic [36:0] expect_q [$];
    logic [31:0] rng;
    int          value_errors;
    int          other_errors;

    rv_core_top dut (
        .clk       (clk),
        .reset     (reset),
        .instr     (instr),
        .instr_req (instr_req),
        .instr_ack (instr_ack),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data)
    );

    bind rv_core_top rv_core_assertions u_checks (
        .clk       (clk),
        .reset     (reset),
        .instr_req (instr_req),
        .instr_ack (instr_ack),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, OPC_REG};
    endfunction

    function automatic logic [31:0] i_type(input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, OPC_IMM};
    endfunction

    // architectural result of one instruction against the shadow registers
    function automatic logic [31:0] model_result(input logic [31:0] word, output logic writes);
        logic [6:0]  opc;
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        logic [31:0] res;
        opc = word[6:0];
        a = shadow[word[19:15]];
        b = (opc == OPC_REG) ? shadow[word[24:20]] : {{20{word[31]}}, word[31:20]};
        sh = b[4:0];
        case (word[14:12])
            3'b000: res = (opc == OPC_REG && word[30]) ? a - b : a + b;
            3'b001: res = a << sh;
            // differing signs decide signed order alone
            3'b010: res = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
            3'b011: res = {31'd0, a < b};
            3'b100: res = a ^ b;
            3'b101: begin
                res = a >> sh;
                if (word[30] && a[31]) begin
                    res = res | ~(32'hffff_ffff >> sh);
                end
            end
            3'b110: res = a | b;
            default: res = a & b;
        endcase
        writes = (opc == OPC_REG || opc == OPC_IMM) && (word[11:7] != 5'd0);
        return res;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERR at %0t: %s is %h, expected %h", $time, what, actual, expected);
            value_errors++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // producer side of the four-phase handshake
    task automatic send_instr(input logic [31:0] word);
        instr = word;
        instr_req = 1'b1;
        do next_cycle(); while (!instr_ack);
        instr_req = 1'b0;
        do next_cycle(); while (instr_ack);
    endtask

    task automatic send_checked(input logic [31:0] word, input int gap);
        logic        writes;
        logic [31:0] value;
        value = model_result(word, writes);
        if (writes) begin
            shadow[word[11:7]] = value;
            expect_q.push_back({word[11:7], value});
        end
        repeat (gap) next_cycle();
        send_instr(word);
    endtask

    task automatic drain_writes();
        int waited;
        waited = 0;
        while (expect_q.size() > 0 && waited < 16) begin
            next_cycle();
            waited++;
        end
        // room for a stray pulse from the last instruction
        repeat (3) next_cycle();
        if (expect_q.size() > 0) begin
            $display("%0d expected register writes never arrived", expect_q.size());
            other_errors += expect_q.size();
            expect_q.delete();
        end
    endtask

    // writeback monitor samples mid-cycle while outputs are settled
    always @(negedge clk) begin
        logic [36:0] item;
        if (!reset && wb_valid) begin
            if (expect_q.size() == 0) begin
                $display("unexpected register write to x%0d at %0t", wb_rd, $time);
                other_errors++;
            end else begin
                item = expect_q.pop_front();
                check_value(32'(wb_rd), 32'(item[36:32]), "wb_rd");
                check_value(wb_data, item[31:0], "wb_data");
            end
        end
    end

    task automatic after_reset();
        check_value(32'(instr_ack), 32'd0, "instr_ack after reset");
        check_value(32'(wb_valid), 32'd0, "wb_valid after reset");
        send_checked(r_type(7'd0, 3'b000, 5'd3, 5'd1, 5'd2), 0);
        drain_writes();
    endtask

    task automatic immediate_ops();
        send_checked(i_type(3'b000, 5'd1, 5'd0, 12'd100), 0);
        send_checked(i_type(3'b000, 5'd2, 5'd0, 12'hffb), 1);
        send_checked(i_type(3'b000, 5'd3, 5'd0, 12'h7ff), 2);
        send_checked(i_type(3'b000, 5'd4, 5'd0, 12'h800), 0);
        send_checked(i_type(3'b010, 5'd5, 5'd2, 12'hfff), 0);
        send_checked(i_type(3'b010, 5'd6, 5'd1, 12'hfff), 1);
        // unsigned compare against a sign-extended negative immediate
        send_checked(i_type(3'b011, 5'd7, 5'd1, 12'hfff), 0);
        send_checked(i_type(3'b011, 5'd8, 5'd2, 12'd5), 0);
        send_checked(i_type(3'b100, 5'd9, 5'd2, 12'hfff), 1);
        send_checked(i_type(3'b110, 5'd10, 5'd1, 12'h0f0), 0);
        send_checked(i_type(3'b111, 5'd11, 5'd2, 12'h7f0), 0);
        drain_writes();
    endtask

    task automatic reg_reg_ops();
        send_checked(i_type(3'b000, 5'd12, 5'd0, 12'hb2e), 0);
        send_checked(i_type(3'b000, 5'd13, 5'd0, 12'h5a5), 0);
        send_checked(i_type(3'b001, 5'd13, 5'd13, 12'd20), 0);
        send_checked(i_type(3'b000, 5'd14, 5'd0, 12'd1), 0);
        send_checked(i_type(3'b000, 5'd15, 5'd0, 12'd31), 0);
        send_checked(r_type(7'd0, 3'b000, 5'd16, 5'd12, 5'd13), 1);
        send_checked(r_type(ALT_F7, 3'b000, 5'd17, 5'd12, 5'd13), 1);
        send_checked(r_type(7'd0, 3'b001, 5'd18, 5'd13, 5'd14), 1);
        send_checked(r_type(7'd0, 3'b010, 5'd19, 5'd12, 5'd13), 1);
        send_checked(r_type(7'd0, 3'b011, 5'd20, 5'd12, 5'd13), 1);
        send_checked(r_type(7'd0, 3'b100, 5'd21, 5'd12, 5'd13), 1);
        send_checked(r_type(7'd0, 3'b101, 5'd22, 5'd12, 5'd15), 1);
        send_checked(r_type(ALT_F7, 3'b101, 5'd23, 5'd12, 5'd15), 1);
        send_checked(r_type(7'd0, 3'b110, 5'd24, 5'd12, 5'd13), 1);
        send_checked(r_type(7'd0, 3'b111, 5'd25, 5'd12, 5'd13), 1);
        send_checked(r_type(7'd0, 3'b001, 5'd26, 5'd12, 5'd0), 1);
        send_checked(r_type(ALT_F7, 3'b101, 5'd27, 5'd12, 5'd14), 1);
        send_checked(r_type(7'd0, 3'b101, 5'd28, 5'd13, 5'd14), 1);
        send_checked(r_type(ALT_F7, 3'b101, 5'd29, 5'd13, 5'd0), 1);
        send_checked(r_type(7'd0, 3'b001, 5'd30, 5'd14, 5'd15), 1);
        drain_writes();
    endtask

    // back to back with each reading the rd just before it
    task automatic forwarding_chain();
        send_checked(i_type(3'b000, 5'd1, 5'd0, 12'd7), 0);
        send_checked(r_type(7'd0, 3'b000, 5'd2, 5'd1, 5'd1), 0);
        send_checked(r_type(ALT_F7, 3'b000, 5'd3, 5'd0, 5'd2), 0);
        send_checked(r_type(ALT_F7, 3'b101, 5'd4, 5'd3, 5'd14), 0);
        send_checked(i_type(3'b001, 5'd5, 5'd4, 12'd3), 0);
        send_checked(r_type(7'd0, 3'b011, 5'd6, 5'd0, 5'd5), 0);
        send_checked(i_type(3'b000, 5'd6, 5'd6, 12'd5), 0);
        drain_writes();
    endtask

    task automatic non_writing_ops();
        send_checked(i_type(3'b000, 5'd0, 5'd1, 12'd5), 0);
        send_checked(r_type(7'd0, 3'b000, 5'd30, 5'd0, 5'd14), 0);
        // store and branch with nonzero bits where rd would sit
        send_checked({7'd0, 5'd1, 5'd2, 3'b010, 5'd9, 7'b0100011}, 0);
        send_checked({7'd0, 5'd1, 5'd1, 3'b000, 5'd12, 7'b1100011}, 0);
        send_checked(r_type(7'd0, 3'b000, 5'd29, 5'd12, 5'd0), 0);
        send_checked(r_type(7'd0, 3'b110, 5'd31, 5'd0, 5'd0), 1);
        drain_writes();
    endtask

    task automatic random_stream();
        logic [31:0] r;
        logic [31:0] r_imm;
        logic [11:0] imm;
        logic [2:0]  f3;
        logic [31:0] word;
        for (int n = 0; n < RANDOM_INSTRS; n++) begin
            r = xorshift();
            r_imm = xorshift();
            imm = r_imm[11:0];
            f3 = r[17:15];
            if (r[18]) begin
                word = r_type((r[19] && (f3 == 3'b000 || f3 == 3'b101)) ? ALT_F7 : 7'd0,
                              f3, r[4:0], r[9:5], r[14:10]);
            end else begin
                if (f3 == 3'b001) begin
                    imm[11:5] = 7'd0;
                end else if (f3 == 3'b101) begin
                    imm[11:5] = r[19] ? ALT_F7 : 7'd0;
                end
                word = i_type(f3, r[4:0], r[9:5], imm);
            end
            send_checked(word, int'(r[21:20]));
        end
        drain_writes();
    endtask

    initial begin
        rng = SEED;
        value_errors = 0;
        other_errors = 0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        reset = 1'b1;
        instr = '0;
        instr_req = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        after_reset();
        immediate_ops();
        reg_reg_ops();
        forwarding_chain();
        non_writing_ops();
        random_stream();

        $display("error counts: %0d value, %0d other, %0d assertion", value_errors,
                 other_errors, dut.u_checks.failures);
        if (value_errors == 0 && other_errors == 0 && dut.u_checks.failures == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+hw
hw/rv_pkg.sv
hw/issue_if.sv
hw/result_if.sv
hw/instr_fetch.sv
hw/instr_decode.sv
hw/alu_execute.sv
hw/reg_file.sv
hw/rv_core_top.sv
sim/rv_core_assertions.sv
sim/rv_core_tb.sv
